//--- ex_ops_pkg.sv
package ex_ops_pkg;

    // ALU operation select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_srl  = 4'd3,
        alu_sra  = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_a    = 4'd10,
        alu_b    = 4'd11,
        alu_b4   = 4'd12,
        alu_idle = 4'd13
    } alu_op_t;

    // Same codes as the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'd0,
        bne  = 3'd1,
        blt  = 3'd4,
        bge  = 3'd5,
        bltu = 3'd6,
        bgeu = 3'd7
    } branch_cond_t;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_cond = 2'd1,
        br_jump = 2'd2
    } branch_kind_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_kind_t;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_t;

endpackage

//--- ex_result_pkg.sv
package ex_result_pkg;

    parameter int XLEN = 64;

    typedef enum logic [1:0] {
        cause_none             = 2'd0,
        cause_ins_misaligned   = 2'd1,
        cause_load_misaligned  = 2'd2,
        cause_store_misaligned = 2'd3
    } cause_t;

    // One executed operation on its way to commit
    typedef struct packed {
        logic [XLEN-1:0]       data;
        logic                  taken;
        logic [XLEN-1:0]       target;
        ex_ops_pkg::mem_kind_t mem_kind;
        ex_ops_pkg::mem_size_t mem_size;
    } ex_result_t;

endpackage

//--- ex_alu_issue.sv
module ex_alu_issue #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             CLK,
    input  logic                             RST,
    input  logic                             issue_valid,
    input  logic                             issue_word,
    input  ex_ops_pkg::alu_op_t              issue_op,
    input  ex_ops_pkg::branch_cond_t         issue_cond,
    input  ex_ops_pkg::branch_kind_t         issue_branch,
    input  ex_ops_pkg::mem_kind_t            issue_mem_kind,
    input  ex_ops_pkg::mem_size_t            issue_mem_size,
    input  logic [ex_result_pkg::XLEN-1:0]   issue_a,
    input  logic [ex_result_pkg::XLEN-1:0]   issue_b,
    input  logic [ex_result_pkg::XLEN-1:0]   issue_cmp1,
    input  logic [ex_result_pkg::XLEN-1:0]   issue_cmp2,
    input  logic [ex_result_pkg::XLEN-1:0]   issue_jump_base,
    input  logic [ex_result_pkg::XLEN-1:0]   issue_jump_offset,
    input  logic                             credit_return,
    output logic                             issue_ready,
    output logic                             push,
    output ex_result_pkg::ex_result_t        push_data
);
    import ex_ops_pkg::*;
    import ex_result_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] credits;
    logic [XLEN-1:0]  alu_res;
    logic [XLEN-1:0]  sra_d;
    logic [31:0]      add_w;
    logic [31:0]      sub_w;
    logic [31:0]      sll_w;
    logic [31:0]      srl_w;
    logic [31:0]      sra_w;
    logic             cmp_hit;
    logic             taken;

    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] val);
        return {{(XLEN-32){val[31]}}, val};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    // Word variants use the low 32 bits and a 5-bit shift amount
    assign add_w = issue_a[31:0] + issue_b[31:0];
    assign sub_w = issue_b[31:0] - issue_a[31:0];
    assign sll_w = issue_b[31:0] << issue_a[4:0];
    assign srl_w = issue_b[31:0] >> issue_a[4:0];
    assign sra_w = $signed(issue_b[31:0]) >>> issue_a[4:0];

    // Full-width arithmetic shift
    assign sra_d = $signed(issue_b) >>> issue_a[5:0];

    always_comb
    begin
        case (issue_op)
            alu_add:  alu_res = issue_word ? sext_w(add_w) : issue_a + issue_b;
            alu_sub:  alu_res = issue_word ? sext_w(sub_w) : issue_b - issue_a;
            alu_sll:  alu_res = issue_word ? sext_w(sll_w) : issue_b << issue_a[5:0];
            alu_srl:  alu_res = issue_word ? sext_w(srl_w) : issue_b >> issue_a[5:0];
            alu_sra:  alu_res = issue_word ? sext_w(sra_w) : sra_d;
            alu_xor:  alu_res = issue_a ^ issue_b;
            alu_or:   alu_res = issue_a | issue_b;
            alu_and:  alu_res = issue_a & issue_b;
            alu_slt:  alu_res = {{(XLEN-1){1'b0}}, $signed(issue_b) < $signed(issue_a)};
            alu_sltu: alu_res = {{(XLEN-1){1'b0}}, issue_b < issue_a};
            alu_a:    alu_res = issue_a;
            alu_b:    alu_res = issue_b;
            alu_b4:   alu_res = issue_b + XLEN'(4);
            default:  alu_res = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch resolution
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (issue_cond)
            beq:     cmp_hit = issue_cmp1 == issue_cmp2;
            bne:     cmp_hit = issue_cmp1 != issue_cmp2;
            blt:     cmp_hit = $signed(issue_cmp1) < $signed(issue_cmp2);
            bge:     cmp_hit = $signed(issue_cmp1) >= $signed(issue_cmp2);
            bltu:    cmp_hit = issue_cmp1 < issue_cmp2;
            bgeu:    cmp_hit = issue_cmp1 >= issue_cmp2;
            default: cmp_hit = 1'b0;
        endcase

        case (issue_branch)
            br_jump: taken = 1'b1;
            br_cond: taken = cmp_hit;
            default: taken = 1'b0;
        endcase
    end

    always_comb
    begin
        push_data.data     = alu_res;
        push_data.taken    = taken;
        push_data.target   = issue_jump_base + issue_jump_offset;
        push_data.mem_kind = issue_mem_kind;
        push_data.mem_size = issue_mem_size;
    end

    //////////////////////////////////////////////////////////////////////
    // Credits
    //////////////////////////////////////////////////////////////////////

    assign issue_ready = credits != '0;
    assign push        = issue_valid && issue_ready;

    // Simultaneous spend and return cancel out
    always_ff @(posedge CLK)
    begin
        if (RST)
            credits <= CNT_W'(FIFO_DEPTH);
        else if (push && !credit_return)
            credits <= credits - 1'b1;
        else if (!push && credit_return)
            credits <= credits + 1'b1;
    end

endmodule

//--- ex_result_fifo.sv
module ex_result_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      push,
    input  logic                      pop,
    input  ex_result_pkg::ex_result_t push_data,
    output logic                      head_valid,
    output ex_result_pkg::ex_result_t head_data
);
    import ex_result_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ex_result_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             rd_en;

    assign head_valid = count != '0;
    assign head_data  = mem[rd_ptr];
    assign rd_en      = pop && head_valid;

    always_ff @(posedge CLK)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // Pointers wrap at FIFO_DEPTH so any depth works
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !rd_en)
                count <= count + 1'b1;
            else if (!push && rd_en)
                count <= count - 1'b1;
        end
    end

endmodule

//--- ex_commit.sv
module ex_commit (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           head_valid,
    input  logic                           res_ready,
    input  ex_result_pkg::ex_result_t      head_data,
    output logic                           pop,
    output logic                           credit_return,
    output logic                           res_valid,
    output logic                           res_taken,
    output logic [ex_result_pkg::XLEN-1:0] res_data,
    output logic [ex_result_pkg::XLEN-1:0] res_target,
    output ex_result_pkg::cause_t          res_cause
);
    import ex_ops_pkg::*;
    import ex_result_pkg::*;

    logic addr_mis;

    assign res_valid  = head_valid;
    assign res_taken  = head_data.taken;
    assign res_data   = head_data.data;
    assign res_target = head_data.target;
    assign pop        = head_valid && res_ready;

    // ALU add result is the data address
    always_comb
    begin
        case (head_data.mem_size)
            size_half:   addr_mis = head_data.data[0];
            size_word:   addr_mis = |head_data.data[1:0];
            size_double: addr_mis = |head_data.data[2:0];
            default:     addr_mis = 1'b0;
        endcase

        res_cause = cause_none;
        if (head_data.taken && (|head_data.target[1:0]))
            res_cause = cause_ins_misaligned;
        else if (head_data.mem_kind == mem_load && addr_mis)
            res_cause = cause_load_misaligned;
        else if (head_data.mem_kind == mem_store && addr_mis)
            res_cause = cause_store_misaligned;
    end

    // One credit back per retired entry
    always_ff @(posedge CLK)
    begin
        if (RST)
            credit_return <= 1'b0;
        else
            credit_return <= pop;
    end

endmodule

//--- ex_stage.sv
module ex_stage #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           issue_valid,
    input  logic                           issue_word,
    input  ex_ops_pkg::alu_op_t            issue_op,
    input  ex_ops_pkg::branch_cond_t       issue_cond,
    input  ex_ops_pkg::branch_kind_t       issue_branch,
    input  ex_ops_pkg::mem_kind_t          issue_mem_kind,
    input  ex_ops_pkg::mem_size_t          issue_mem_size,
    input  logic [ex_result_pkg::XLEN-1:0] issue_a,
    input  logic [ex_result_pkg::XLEN-1:0] issue_b,
    input  logic [ex_result_pkg::XLEN-1:0] issue_cmp1,
    input  logic [ex_result_pkg::XLEN-1:0] issue_cmp2,
    input  logic [ex_result_pkg::XLEN-1:0] issue_jump_base,
    input  logic [ex_result_pkg::XLEN-1:0] issue_jump_offset,
    output logic                           issue_ready,
    input  logic                           res_ready,
    output logic                           res_valid,
    output logic                           res_taken,
    output logic [ex_result_pkg::XLEN-1:0] res_data,
    output logic [ex_result_pkg::XLEN-1:0] res_target,
    output ex_result_pkg::cause_t          res_cause
);
    import ex_result_pkg::*;

    logic       push;
    logic       pop;
    logic       head_valid;
    logic       credit_return;
    ex_result_t push_data;
    ex_result_t head_data;

    ex_alu_issue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_issue (
        .CLK               (CLK),
        .RST               (RST),
        .issue_valid       (issue_valid),
        .issue_word        (issue_word),
        .issue_op          (issue_op),
        .issue_cond        (issue_cond),
        .issue_branch      (issue_branch),
        .issue_mem_kind    (issue_mem_kind),
        .issue_mem_size    (issue_mem_size),
        .issue_a           (issue_a),
        .issue_b           (issue_b),
        .issue_cmp1        (issue_cmp1),
        .issue_cmp2        (issue_cmp2),
        .issue_jump_base   (issue_jump_base),
        .issue_jump_offset (issue_jump_offset),
        .credit_return     (credit_return),
        .issue_ready       (issue_ready),
        .push              (push),
        .push_data         (push_data)
    );

    // Sized by the credit count, so no full flag is needed
    ex_result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK        (CLK),
        .RST        (RST),
        .push       (push),
        .pop        (pop),
        .push_data  (push_data),
        .head_valid (head_valid),
        .head_data  (head_data)
    );

    ex_commit u_commit (
        .CLK           (CLK),
        .RST           (RST),
        .head_valid    (head_valid),
        .res_ready     (res_ready),
        .head_data     (head_data),
        .pop           (pop),
        .credit_return (credit_return),
        .res_valid     (res_valid),
        .res_taken     (res_taken),
        .res_data      (res_data),
        .res_target    (res_target),
        .res_cause     (res_cause)
    );

endmodule

//--- tb_ex_stage.sv
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import ex_ops_pkg::*;
    import ex_result_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int MAX_OPS    = 64;
    localparam int N_FIELDS   = 16;

    logic         CLK = 1'b0;
    logic         RST;
    logic         issue_valid;
    logic         issue_word;
    alu_op_t      issue_op;
    branch_cond_t issue_cond;
    branch_kind_t issue_branch;
    mem_kind_t    issue_mem_kind;
    mem_size_t    issue_mem_size;
    logic [63:0]  issue_a;
    logic [63:0]  issue_b;
    logic [63:0]  issue_cmp1;
    logic [63:0]  issue_cmp2;
    logic [63:0]  issue_jump_base;
    logic [63:0]  issue_jump_offset;
    logic         issue_ready;
    logic         res_ready;
    logic         res_valid;
    logic         res_taken;
    logic [63:0]  res_data;
    logic [63:0]  res_target;
    cause_t       res_cause;

    // Columns 0..11 are stimulus, 12..15 expected data, taken, target, cause
    logic [63:0] trace_mem [MAX_OPS][N_FIELDS];
    int          n_ops;
    int          next_idx;
    int          done_cnt;
    int          cycles;
    int          errors;
    int          checks;
    int          done_d1;
    int          done_d2;
    int          exp_q [$];

    ex_stage #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (.*);

    always #2 CLK = ~CLK;

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic drive_op(input int i);
        issue_valid       <= 1'b1;
        issue_op          <= alu_op_t'(trace_mem[i][0][3:0]);
        issue_word        <= trace_mem[i][1][0];
        issue_branch      <= branch_kind_t'(trace_mem[i][2][1:0]);
        issue_cond        <= branch_cond_t'(trace_mem[i][3][2:0]);
        issue_mem_kind    <= mem_kind_t'(trace_mem[i][4][1:0]);
        issue_mem_size    <= mem_size_t'(trace_mem[i][5][1:0]);
        issue_a           <= trace_mem[i][6];
        issue_b           <= trace_mem[i][7];
        issue_cmp1        <= trace_mem[i][8];
        issue_cmp2        <= trace_mem[i][9];
        issue_jump_base   <= trace_mem[i][10];
        issue_jump_offset <= trace_mem[i][11];
    endtask

    //////////////////////////////////////////////////////////////////////
    // Issue, scoreboard and flow-control checks
    //////////////////////////////////////////////////////////////////////

    always @(posedge CLK)
    begin
        int idx;
        int done_now;
        done_now = 0;
        if (!RST)
        begin
            cycles++;
            if (cycles == 1)
            begin
                void'($urandom(32'hd93d9031));
                compare_field("issue_ready", 64'(1), 64'(issue_ready));
                compare_field("res_valid", 64'(0), 64'(res_valid));
            end
            // Credit from a pop two edges back must be usable by now
            if (done_d2 != 0 && (exp_q.size() + done_d1) < FIFO_DEPTH)
                compare_field("issue_ready", 64'(1), 64'(issue_ready));

            if (res_valid && res_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("ERROR: result at t=%0t with no operation outstanding", $time);
                end
                else
                begin
                    idx = exp_q.pop_front();
                    compare_field("res_data", trace_mem[idx][12], res_data);
                    compare_field("res_taken", trace_mem[idx][13], 64'(res_taken));
                    compare_field("res_target", trace_mem[idx][14], res_target);
                    compare_field("res_cause", trace_mem[idx][15], 64'(res_cause));
                    done_cnt++;
                end
                done_now = 1;
            end

            if (issue_valid && issue_ready)
            begin
                exp_q.push_back(next_idx);
                next_idx++;
            end
            if (exp_q.size() > FIFO_DEPTH)
            begin
                errors++;
                $display("ERROR: more than %0d records in flight at t=%0t", FIFO_DEPTH, $time);
            end

            done_d2 = done_d1;
            done_d1 = done_now;
            if (next_idx < n_ops)
                drive_op(next_idx);
            else
                issue_valid <= 1'b0;
            // Back-pressure about 30 percent of the time
            res_ready <= ($urandom % 100) >= 30;
        end
    end

    initial
    begin
        int          fd;
        int          cnt;
        int          limit;
        string       line;
        logic [63:0] f [N_FIELDS];

        RST = 1'b1;
        issue_valid = 1'b0;
        issue_word = 1'b0;
        issue_op = alu_idle;
        issue_cond = beq;
        issue_branch = br_none;
        issue_mem_kind = mem_none;
        issue_mem_size = size_byte;
        issue_a = '0;
        issue_b = '0;
        issue_cmp1 = '0;
        issue_cmp2 = '0;
        issue_jump_base = '0;
        issue_jump_offset = '0;
        res_ready = 1'b0;
        n_ops = 0;
        next_idx = 0;
        done_cnt = 0;
        cycles = 0;
        errors = 0;
        checks = 0;
        done_d1 = 0;
        done_d2 = 0;

        fd = $fopen("ex_trace.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("ERROR: cannot open ex_trace.txt");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                  f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (cnt == N_FIELDS && n_ops < MAX_OPS)
                    begin
                        for (int k = 0; k < N_FIELDS; k++)
                            trace_mem[n_ops][k] = f[k];
                        n_ops++;
                    end
                    else
                    begin
                        errors++;
                        $display("ERROR: trace entry %0d could not be read", n_ops + 1);
                    end
                end
            end
            $fclose(fd);
            if (n_ops == 0)
            begin
                errors++;
                $display("ERROR: trace file holds no operations");
            end
        end
        limit = 40 * n_ops + 100;

        repeat (5) @(posedge CLK);
        RST <= 1'b0;
        while (done_cnt < n_ops && cycles < limit)
            @(posedge CLK);
        if (done_cnt < n_ops)
        begin
            errors++;
            $display("ERROR: timeout after %0d cycles, %0d of %0d results seen",
                     cycles, done_cnt, n_ops);
        end

        $display("Errors: %0d  Checks: %0d", errors, checks);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- ex_trace.txt
# op word br cond mem size a b cmp1 cmp2 base offset exp_data exp_taken exp_target exp_cause
# All columns hex; op, kinds and cause use the package encodings
0 0 0 0 0 0 5 7 0 0 0 0 c 0 0 0
1 0 0 0 0 0 5 3 0 0 0 0 fffffffffffffffe 0 0 0
2 0 0 0 0 0 44 3 0 0 0 0 30 0 0 0
3 0 0 0 0 0 3c 8000000000000000 0 0 0 0 8 0 0 0
4 0 0 0 0 0 3c 8000000000000000 0 0 0 0 fffffffffffffff8 0 0 0
5 0 0 0 0 0 ff00 ff0 0 0 0 0 f0f0 0 0 0
6 0 0 0 0 0 ff00 ff0 0 0 0 0 fff0 0 0 0
7 0 0 0 0 0 ff00 ff0 0 0 0 0 f00 0 0 0
8 0 0 0 0 0 1 ffffffffffffffff 0 0 0 0 1 0 0 0
9 0 0 0 0 0 1 ffffffffffffffff 0 0 0 0 0 0 0 0
9 0 0 0 0 0 ffffffffffffffff 1 0 0 0 0 1 0 0 0
a 0 0 0 0 0 123456789abcdef0 1 0 0 0 0 123456789abcdef0 0 0 0
b 0 0 0 0 0 1 cafe 0 0 0 0 cafe 0 0 0
c 0 0 0 0 0 0 1000 0 0 0 0 1004 0 0 0
d 0 0 0 0 0 5 6 0 0 0 0 0 0 0 0
0 1 0 0 0 0 ffffffff00000001 7fffffff 0 0 0 0 ffffffff80000000 0 0 0
1 1 0 0 0 0 1 100000000 0 0 0 0 ffffffffffffffff 0 0 0
2 1 0 0 0 0 3f 1 0 0 0 0 ffffffff80000000 0 0 0
3 1 0 0 0 0 4 ffffffff80000000 0 0 0 0 8000000 0 0 0
4 1 0 0 0 0 4 80000000 0 0 0 0 fffffffff8000000 0 0 0
d 0 1 0 0 0 0 0 5 5 1000 20 0 1 1020 0
d 0 1 1 0 0 0 0 5 5 1000 20 0 0 1020 0
d 0 1 4 0 0 0 0 ffffffffffffffff 1 2000 fffffffffffffff0 0 1 1ff0 0
d 0 1 5 0 0 0 0 ffffffffffffffff 1 2000 fffffffffffffff0 0 0 1ff0 0
d 0 1 6 0 0 0 0 ffffffffffffffff 1 3000 4 0 0 3004 0
d 0 1 7 0 0 0 0 ffffffffffffffff 1 3000 4 0 1 3004 0
c 0 2 0 0 0 0 8000 0 0 4000 8 8004 1 4008 0
c 0 2 0 0 0 0 8000 0 0 4000 2 8004 1 4002 1
d 0 1 0 0 0 0 0 0 0 5000 1 0 1 5001 1
d 0 1 1 0 0 0 0 0 0 5000 1 0 0 5001 0
0 0 0 0 1 0 1000 1 0 0 0 0 1001 0 0 0
0 0 0 0 1 1 1000 1 0 0 0 0 1001 0 0 2
0 0 0 0 2 1 1000 2 0 0 0 0 1002 0 0 0
0 0 0 0 1 2 1000 2 0 0 0 0 1002 0 0 2
0 0 0 0 2 2 1000 4 0 0 0 0 1004 0 0 0
0 0 0 0 2 2 1000 6 0 0 0 0 1006 0 0 3
0 0 0 0 1 3 1000 8 0 0 0 0 1008 0 0 0
0 0 0 0 2 3 1000 4 0 0 0 0 1004 0 0 3

//--- ex_stage.f
ex_ops_pkg.sv
ex_result_pkg.sv
ex_alu_issue.sv
ex_result_fifo.sv
ex_commit.sv
ex_stage.sv
tb_ex_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ex_stage
FILELIST  ?= ex_stage.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "All tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
